//--- rtl/spu_pkg.sv
// spu_pkg: shared widths, opcodes, instruction fields and pipeline stage types
package spu_pkg;

	localparam int QUAD_W     = 128;
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 7;
	localparam int INST_W     = 32;
	localparam int PAIR_W     = 64;
	localparam int ADDR_W     = 32;
	localparam int IMM_W      = 10;
	localparam int PAIR_BYTES = 8;

	typedef logic [QUAD_W-1:0] quad_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// even class first, then the two quad memory ops
	typedef enum logic [7:0] {
		OP_NOP  = 8'h00,
		OP_ADD  = 8'h01,
		OP_AND  = 8'h02,
		OP_OR   = 8'h03,
		OP_XOR  = 8'h04,
		OP_ADDI = 8'h05,
		OP_STQD = 8'h24,
		OP_LQD  = 8'h34
	} op_e;

	// tail is the immediate, or rb in its top 7 bits
	typedef struct packed {
		op_e             op;
		reg_addr_t       rt;
		reg_addr_t       ra;
		logic [IMM_W-1:0] tail;
	} inst_t;

	typedef struct packed {
		op_e               op;
		reg_addr_t         rt;
		quad_t             ra;
		quad_t             rb;
		logic [WORD_W-1:0] imm;
		logic              wreg;
	} issue_t;

	typedef struct packed {
		logic      wreg;
		reg_addr_t rt;
		quad_t     data;
	} wb_t;

endpackage

//--- rtl/spu_fetch.sv
// spu_fetch: program counter and fetch register for the 64-bit instruction pair
`timescale 1ns/100ps

module spu_fetch (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       hold_i,
	input  logic [spu_pkg::PAIR_W-1:0] rom_data_i,
	output logic                       rom_ce_o,
	output spu_pkg::addr_t             rom_addr_o,
	output logic [spu_pkg::PAIR_W-1:0] pair_o
);
	import spu_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rom_ce_o   <= 1'b0;
			rom_addr_o <= '0;
			// all-zero pair decodes as two nops
			pair_o     <= '0;
		end else begin
			rom_ce_o <= 1'b1;
			// no branches, pc only moves forward
			if (!hold_i) begin
				rom_addr_o <= rom_addr_o + addr_t'(PAIR_BYTES);
				pair_o     <= rom_data_i;
			end
		end
	end

endmodule

//--- rtl/spu_decode.sv
// spu_decode: pair split, field decode, scoreboard interlock and dual issue
`timescale 1ns/100ps

module spu_decode (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       stallreq_fr_cache_i,
	input  logic [spu_pkg::PAIR_W-1:0] pair_i,
	input  spu_pkg::quad_t             ra_data_e_i,
	input  spu_pkg::quad_t             rb_data_e_i,
	input  spu_pkg::quad_t             ra_data_o_i,
	input  spu_pkg::quad_t             rb_data_o_i,
	input  spu_pkg::wb_t               wb_e_i,
	input  spu_pkg::wb_t               wb_o_i,
	output spu_pkg::reg_addr_t         ra_addr_e_o,
	output spu_pkg::reg_addr_t         rb_addr_e_o,
	output spu_pkg::reg_addr_t         ra_addr_o_o,
	output spu_pkg::reg_addr_t         rb_addr_o_o,
	output spu_pkg::issue_t            issue_e_o,
	output spu_pkg::issue_t            issue_o_o,
	output logic                       hold_o
);
	import spu_pkg::*;

	inst_t inst_e;
	inst_t inst_o;
	op_e op_ev;
	op_e op_od;
	reg_addr_t rb_e;
	reg_addr_t rb_o;
	logic use_rb_e;
	logic wr_e;
	logic wr_o;
	logic st_o;
	logic st_q;
	logic src_busy;
	logic dst_busy;
	logic [2**REG_ADDR_W-1:0] busy_q;
	logic [2**REG_ADDR_W-1:0] busy_nxt;

	// low word to the even pipe, high word to the odd pipe
	assign inst_e = inst_t'(pair_i[INST_W-1:0]);
	assign inst_o = inst_t'(pair_i[PAIR_W-1:INST_W]);
	assign rb_e = inst_e.tail[IMM_W-1 -: REG_ADDR_W];
	assign rb_o = inst_o.tail[IMM_W-1 -: REG_ADDR_W];

	// an op in the wrong slot runs as a nop
	always_comb begin
		case (inst_e.op)
			OP_ADD, OP_AND, OP_OR, OP_XOR, OP_ADDI: op_ev = inst_e.op;
			default: op_ev = OP_NOP;
		endcase
		case (inst_o.op)
			OP_LQD, OP_STQD: op_od = inst_o.op;
			default: op_od = OP_NOP;
		endcase
	end

	assign wr_e = (op_ev != OP_NOP);
	assign use_rb_e = wr_e && (op_ev != OP_ADDI);
	assign wr_o = (op_od == OP_LQD);
	assign st_o = (op_od == OP_STQD);

	assign ra_addr_e_o = inst_e.ra;
	assign rb_addr_e_o = rb_e;
	assign ra_addr_o_o = inst_o.ra;
	// a store reads its data register on the second port
	assign rb_addr_o_o = st_o ? inst_o.rt : rb_o;

	assign src_busy = (wr_e && busy_q[inst_e.ra]) || (use_rb_e && busy_q[rb_e]) ||
		((wr_o || st_o) && busy_q[inst_o.ra]) || (st_o && busy_q[inst_o.rt]);
	// a second pending write to one register would be cleared by the first
	assign dst_busy = (wr_e && busy_q[inst_e.rt]) || (wr_o && busy_q[inst_o.rt]);
	// stores are spaced so the memory strobe stays a single-cycle pulse
	assign hold_o = stallreq_fr_cache_i || src_busy || dst_busy || (st_o && st_q);

	always_comb begin
		issue_e_o.op   = hold_o ? OP_NOP : op_ev;
		issue_e_o.rt   = inst_e.rt;
		issue_e_o.ra   = ra_data_e_i;
		issue_e_o.rb   = rb_data_e_i;
		issue_e_o.imm  = {{(WORD_W-IMM_W){inst_e.tail[IMM_W-1]}}, inst_e.tail};
		issue_e_o.wreg = wr_e && !hold_o;
		issue_o_o.op   = hold_o ? OP_NOP : op_od;
		issue_o_o.rt   = inst_o.rt;
		issue_o_o.ra   = ra_data_o_i;
		issue_o_o.rb   = rb_data_o_i;
		issue_o_o.imm  = {{(WORD_W-IMM_W){inst_o.tail[IMM_W-1]}}, inst_o.tail};
		issue_o_o.wreg = wr_o && !hold_o;
	end

	// clear on write back first, so a new mark on the same register wins
	always_comb begin
		busy_nxt = busy_q;
		if (wb_e_i.wreg)
			busy_nxt[wb_e_i.rt] = 1'b0;
		if (wb_o_i.wreg)
			busy_nxt[wb_o_i.rt] = 1'b0;
		if (issue_e_o.wreg)
			busy_nxt[inst_e.rt] = 1'b1;
		if (issue_o_o.wreg)
			busy_nxt[inst_o.rt] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_q <= '0;
			st_q   <= 1'b0;
		end else begin
			busy_q <= busy_nxt;
			st_q   <= st_o && !hold_o;
		end
	end

endmodule

//--- rtl/spu_regfile.sv
// spu_regfile: 128 x 128-bit register file, four read ports and two write ports
`timescale 1ns/100ps

module spu_regfile (
	input  logic               clk,
	input  spu_pkg::reg_addr_t ra_addr_e_i,
	input  spu_pkg::reg_addr_t rb_addr_e_i,
	input  spu_pkg::reg_addr_t ra_addr_o_i,
	input  spu_pkg::reg_addr_t rb_addr_o_i,
	input  spu_pkg::wb_t       wb_e_i,
	input  spu_pkg::wb_t       wb_o_i,
	output spu_pkg::quad_t     ra_data_e_o,
	output spu_pkg::quad_t     rb_data_e_o,
	output spu_pkg::quad_t     ra_data_o_o,
	output spu_pkg::quad_t     rb_data_o_o
);
	import spu_pkg::*;

	quad_t regs [2**REG_ADDR_W];
	logic e_wins;

	// odd port takes the register when both write the same one
	assign e_wins = wb_e_i.wreg && !(wb_o_i.wreg && (wb_o_i.rt == wb_e_i.rt));

	always_ff @(posedge clk) begin
		if (e_wins)
			regs[wb_e_i.rt] <= wb_e_i.data;
		if (wb_o_i.wreg)
			regs[wb_o_i.rt] <= wb_o_i.data;
	end

	// reads see the file as it stood before this edge
	assign ra_data_e_o = regs[ra_addr_e_i];
	assign rb_data_e_o = regs[rb_addr_e_i];
	assign ra_data_o_o = regs[ra_addr_o_i];
	assign rb_data_o_o = regs[rb_addr_o_i];

endmodule

//--- rtl/spu_even_pipe.sv
// spu_even_pipe: even execute stage with word-wise add and logic ops
`timescale 1ns/100ps

module spu_even_pipe (
	input  logic            clk,
	input  logic            rst_n_i,
	input  spu_pkg::issue_t issue_i,
	output spu_pkg::wb_t    wb_o
);
	import spu_pkg::*;

	localparam int WORDS = QUAD_W / WORD_W;

	issue_t ex_q;
	quad_t res;

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			ex_q <= '0;
		else
			ex_q <= issue_i;
	end

	// each 32-bit word on its own, no carry between words
	always_comb begin
		res = '0;
		for (int w = 0; w < WORDS; w++) begin
			case (ex_q.op)
				OP_ADD:  res[w*WORD_W +: WORD_W] = ex_q.ra[w*WORD_W +: WORD_W] +
					ex_q.rb[w*WORD_W +: WORD_W];
				OP_AND:  res[w*WORD_W +: WORD_W] = ex_q.ra[w*WORD_W +: WORD_W] &
					ex_q.rb[w*WORD_W +: WORD_W];
				OP_OR:   res[w*WORD_W +: WORD_W] = ex_q.ra[w*WORD_W +: WORD_W] |
					ex_q.rb[w*WORD_W +: WORD_W];
				OP_XOR:  res[w*WORD_W +: WORD_W] = ex_q.ra[w*WORD_W +: WORD_W] ^
					ex_q.rb[w*WORD_W +: WORD_W];
				OP_ADDI: res[w*WORD_W +: WORD_W] = ex_q.ra[w*WORD_W +: WORD_W] + ex_q.imm;
				default: res[w*WORD_W +: WORD_W] = '0;
			endcase
		end
	end

	assign wb_o = '{wreg: ex_q.wreg, rt: ex_q.rt, data: res};

endmodule

//--- rtl/spu_odd_pipe.sv
// spu_odd_pipe: odd execute stage, quad address generation and data memory access
`timescale 1ns/100ps

module spu_odd_pipe (
	input  logic            clk,
	input  logic            rst_n_i,
	input  spu_pkg::issue_t issue_i,
	input  spu_pkg::quad_t  rt_from_memory_i,
	output spu_pkg::addr_t  mem_data_addr_o,
	output logic            write_memory_enable_o,
	output spu_pkg::quad_t  rt_to_memory_o,
	output spu_pkg::wb_t    wb_o
);
	import spu_pkg::*;

	issue_t ex_q;
	addr_t ea;

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			ex_q <= '0;
		else
			ex_q <= issue_i;
	end

	// word 0 of ra plus the immediate scaled to quads
	assign ea = ex_q.ra[ADDR_W-1:0] + {ex_q.imm[ADDR_W-5:0], 4'b0000};
	assign mem_data_addr_o = {ea[ADDR_W-1:4], 4'b0000};

	// store data came in on the second read port
	assign write_memory_enable_o = (ex_q.op == OP_STQD);
	assign rt_to_memory_o = ex_q.rb;

	assign wb_o = '{wreg: ex_q.wreg, rt: ex_q.rt,
		data: (ex_q.op == OP_LQD) ? rt_from_memory_i : '0};

endmodule

//--- rtl/spu_result_pipe.sv
// spu_result_pipe: result delay network of DEPTH stages ahead of write back
`timescale 1ns/100ps

module spu_result_pipe #(
	parameter int DEPTH = 7
) (
	input  logic         clk,
	input  logic         rst_n_i,
	input  spu_pkg::wb_t wb_i,
	output spu_pkg::wb_t wb_o
);
	import spu_pkg::*;

	wb_t stage_q [DEPTH];

	// only the write enables need clearing
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < DEPTH; i++)
				stage_q[i].wreg <= 1'b0;
		end else begin
			stage_q[0] <= wb_i;
			for (int i = 1; i < DEPTH; i++)
				stage_q[i] <= stage_q[i-1];
		end
	end

	assign wb_o = stage_q[DEPTH-1];

endmodule

//--- rtl/spu_top.sv
// spu_top: dual-issue SPU datapath with fetch, decode, register file, two pipes
`timescale 1ns/100ps

module spu_top #(
	parameter int RESULT_DEPTH = 7
) (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        stallreq_fr_cache_i,
	input  logic [spu_pkg::PAIR_W-1:0]  rom_data_i,
	input  spu_pkg::quad_t              rt_from_memory_i,
	output logic                        rom_ce_o,
	output spu_pkg::addr_t              rom_addr_o,
	output spu_pkg::addr_t              mem_data_addr_o,
	output logic                        write_memory_enable_o,
	output spu_pkg::quad_t              rt_to_memory_o
);
	import spu_pkg::*;

	logic [PAIR_W-1:0] pair;
	logic hold;
	reg_addr_t ra_addr_e;
	reg_addr_t rb_addr_e;
	reg_addr_t ra_addr_o;
	reg_addr_t rb_addr_o;
	quad_t ra_data_e;
	quad_t rb_data_e;
	quad_t ra_data_o;
	quad_t rb_data_o;
	issue_t issue_e;
	issue_t issue_o;
	wb_t ex_wb_e;
	wb_t ex_wb_o;
	wb_t wb_e;
	wb_t wb_o;

	spu_fetch fetch_inst (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.hold_i     (hold),
		.rom_data_i (rom_data_i),
		.rom_ce_o   (rom_ce_o),
		.rom_addr_o (rom_addr_o),
		.pair_o     (pair)
	);

	spu_decode decode_inst (
		.clk                 (clk),
		.rst_n_i             (rst_n_i),
		.stallreq_fr_cache_i (stallreq_fr_cache_i),
		.pair_i              (pair),
		.ra_data_e_i         (ra_data_e),
		.rb_data_e_i         (rb_data_e),
		.ra_data_o_i         (ra_data_o),
		.rb_data_o_i         (rb_data_o),
		.wb_e_i              (wb_e),
		.wb_o_i              (wb_o),
		.ra_addr_e_o         (ra_addr_e),
		.rb_addr_e_o         (rb_addr_e),
		.ra_addr_o_o         (ra_addr_o),
		.rb_addr_o_o         (rb_addr_o),
		.issue_e_o           (issue_e),
		.issue_o_o           (issue_o),
		.hold_o              (hold)
	);

	spu_regfile regfile_inst (
		.clk         (clk),
		.ra_addr_e_i (ra_addr_e),
		.rb_addr_e_i (rb_addr_e),
		.ra_addr_o_i (ra_addr_o),
		.rb_addr_o_i (rb_addr_o),
		.wb_e_i      (wb_e),
		.wb_o_i      (wb_o),
		.ra_data_e_o (ra_data_e),
		.rb_data_e_o (rb_data_e),
		.ra_data_o_o (ra_data_o),
		.rb_data_o_o (rb_data_o)
	);

	spu_even_pipe even_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.issue_i (issue_e),
		.wb_o    (ex_wb_e)
	);

	spu_odd_pipe odd_inst (
		.clk                   (clk),
		.rst_n_i               (rst_n_i),
		.issue_i               (issue_o),
		.rt_from_memory_i      (rt_from_memory_i),
		.mem_data_addr_o       (mem_data_addr_o),
		.write_memory_enable_o (write_memory_enable_o),
		.rt_to_memory_o        (rt_to_memory_o),
		.wb_o                  (ex_wb_o)
	);

	// both networks have the same depth, so a pair writes back together
	spu_result_pipe #(.DEPTH(RESULT_DEPTH)) result_e_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.wb_i    (ex_wb_e),
		.wb_o    (wb_e)
	);

	spu_result_pipe #(.DEPTH(RESULT_DEPTH)) result_o_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.wb_i    (ex_wb_o),
		.wb_o    (wb_o)
	);

endmodule

//--- test/spu_checker.sv
// spu_checker: watches the fetch and store ports and compares against expected values
`timescale 1ns/100ps

module spu_checker #(
	parameter int MAX_ST = 32
) (
	input  logic           clk,
	input  logic           rst_n_i,
	input  logic           stall_i,
	input  logic           rom_ce_i,
	input  spu_pkg::addr_t rom_addr_i,
	input  logic           wme_i,
	input  spu_pkg::addr_t mem_addr_i,
	input  spu_pkg::quad_t mem_data_i,
	input  spu_pkg::addr_t exp_addr_i [MAX_ST],
	input  spu_pkg::quad_t exp_data_i [MAX_ST],
	input  int             exp_count_i,
	output int             store_count_o,
	output int             mismatch_count_o,
	output int             other_count_o
);
	import spu_pkg::*;

	int stores = 0;
	int mismatches = 0;
	int others = 0;
	logic reset_seen = 1'b0;
	logic first_run = 1'b1;
	logic prev_stall = 1'b0;
	addr_t prev_addr = '0;

	always @(posedge clk) begin
		if (!rst_n_i) begin
			if (reset_seen && (rom_ce_i || wme_i)) begin
				$display("Mismatch at %0t: rom_ce %b or store %b high in reset",
					$time, rom_ce_i, wme_i);
				mismatches++;
			end
			reset_seen = 1'b1;
			first_run = 1'b1;
		end else begin
			if (first_run) begin
				if (rom_addr_i != '0) begin
					$display("Mismatch at %0t: first fetch address %h", $time, rom_addr_i);
					mismatches++;
				end
				first_run = 1'b0;
			end else begin
				if (!rom_ce_i) begin
					$display("Mismatch at %0t: rom_ce low after reset", $time);
					mismatches++;
				end
				// a cache stall must freeze the pc
				if (prev_stall && rom_addr_i != prev_addr) begin
					$display("Mismatch at %0t: fetch moved to %h under stall", $time, rom_addr_i);
					mismatches++;
				end else if (rom_addr_i != prev_addr && rom_addr_i != prev_addr + 32'd8) begin
					$display("Mismatch at %0t: fetch jumped %h to %h", $time, prev_addr,
						rom_addr_i);
					mismatches++;
				end
			end
			prev_addr = rom_addr_i;
			prev_stall = stall_i;
			if (wme_i) begin
				if (stores >= exp_count_i) begin
					$display("unexpected extra store to address %h at time %0t",
						mem_addr_i, $time);
					others++;
				end else if (mem_addr_i != exp_addr_i[stores] ||
					mem_data_i != exp_data_i[stores]) begin
					$display("Mismatch at %0t: store %0d got %h/%h expected %h/%h", $time,
						stores, mem_addr_i, mem_data_i, exp_addr_i[stores],
						exp_data_i[stores]);
					mismatches++;
				end
				stores++;
			end
		end
	end

	assign store_count_o = stores;
	assign mismatch_count_o = mismatches;
	assign other_count_o = others;

endmodule

//--- test/spu_asserts.sv
// spu_asserts: bound checks on issue bubbles and the data memory store strobe
`timescale 1ns/100ps

module spu_asserts (
	input logic            clk,
	input logic            rst_n_i,
	input logic            hold_i,
	input spu_pkg::issue_t issue_e_i,
	input spu_pkg::issue_t issue_o_i,
	input spu_pkg::addr_t  mem_data_addr_i,
	input logic            write_memory_enable_i
);
	import spu_pkg::*;

	// a held pair must leave nothing behind in either pipe
	hold_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
		hold_i |-> (!issue_e_i.wreg && !issue_o_i.wreg &&
		issue_e_i.op == OP_NOP && issue_o_i.op == OP_NOP))
		else $error("held pair was issued");

	store_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		write_memory_enable_i |-> (mem_data_addr_i[3:0] == 4'h0))
		else $error("store address not quad aligned");

	store_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		write_memory_enable_i |=> !write_memory_enable_i)
		else $error("store strobe high for two cycles");

endmodule

// decode signals are reached through the top level wires
bind spu_top spu_asserts asserts_inst (
	.clk                   (clk),
	.rst_n_i               (rst_n_i),
	.hold_i                (hold),
	.issue_e_i             (issue_e),
	.issue_o_i             (issue_o),
	.mem_data_addr_i       (mem_data_addr_o),
	.write_memory_enable_i (write_memory_enable_o)
);

//--- test/spu_tb.sv
// spu_tb: drives a small program through the SPU core and checks its stores
`timescale 1ns/100ps

module spu_tb;
	import spu_pkg::*;

	localparam int NPAIRS = 21;
	localparam int ROM_PAIRS = 64;
	localparam int MAX_ST = 32;
	localparam logic [31:0] SEED = 32'he65a;

	logic clk = 1'b0;
	logic rst_n_i;
	logic stallreq_fr_cache_i;
	logic [PAIR_W-1:0] rom_data_i;
	quad_t rt_from_memory_i;
	logic rom_ce_o;
	addr_t rom_addr_o;
	addr_t mem_data_addr_o;
	logic write_memory_enable_o;
	quad_t rt_to_memory_o;

	logic [PAIR_W-1:0] prog [NPAIRS];
	logic [PAIR_W-1:0] rom [ROM_PAIRS];
	quad_t mem [256];
	addr_t exp_addr [MAX_ST];
	quad_t exp_data [MAX_ST];
	int exp_count = 0;
	int store_count;
	int mismatch_count;
	int other_count;
	int timeout_count = 0;

	always #20 clk = ~clk;

	spu_top #(.RESULT_DEPTH(7)) spu_top_inst (
		.clk                   (clk),
		.rst_n_i               (rst_n_i),
		.stallreq_fr_cache_i   (stallreq_fr_cache_i),
		.rom_data_i            (rom_data_i),
		.rt_from_memory_i      (rt_from_memory_i),
		.rom_ce_o              (rom_ce_o),
		.rom_addr_o            (rom_addr_o),
		.mem_data_addr_o       (mem_data_addr_o),
		.write_memory_enable_o (write_memory_enable_o),
		.rt_to_memory_o        (rt_to_memory_o)
	);

	spu_checker #(.MAX_ST(MAX_ST)) checker_inst (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.stall_i          (stallreq_fr_cache_i),
		.rom_ce_i         (rom_ce_o),
		.rom_addr_i       (rom_addr_o),
		.wme_i            (write_memory_enable_o),
		.mem_addr_i       (mem_data_addr_o),
		.mem_data_i       (rt_to_memory_o),
		.exp_addr_i       (exp_addr),
		.exp_data_i       (exp_data),
		.exp_count_i      (exp_count),
		.store_count_o    (store_count),
		.mismatch_count_o (mismatch_count),
		.other_count_o    (other_count)
	);

	// pairs past the table read as nops
	assign rom_data_i = (rom_addr_o < ROM_PAIRS * 8) ? rom[rom_addr_o[8:3]] : '0;
	assign rt_from_memory_i = mem[mem_data_addr_o[11:4]];

	always @(posedge clk) begin
		if (write_memory_enable_o)
			mem[mem_data_addr_o[11:4]] <= rt_to_memory_o;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// unwritten memory, seeded from the full byte address
	function automatic quad_t fill_quad(input logic [31:0] addr);
		logic [31:0] s;
		quad_t q;
		s = SEED ^ addr;
		for (int w = 0; w < 4; w++) begin
			s = lcg_next(s);
			q[w*32 +: 32] = s;
		end
		return q;
	endfunction

	function automatic logic [31:0] enc_rrr(input op_e op, input int rt, input int ra,
		input int rb);
		logic [6:0] b;
		b = rb[6:0];
		return {op, rt[6:0], ra[6:0], b, 3'b000};
	endfunction

	function automatic logic [31:0] enc_rri(input op_e op, input int rt, input int ra,
		input int imm);
		return {op, rt[6:0], ra[6:0], imm[9:0]};
	endfunction

	// word-wise even op on a quad, as the instruction set defines it
	function automatic quad_t even_result(input logic [7:0] op, input quad_t a,
		input quad_t b, input logic [31:0] imm);
		quad_t r;
		r = '0;
		for (int w = 0; w < 4; w++) begin
			case (op)
				OP_ADD:  r[w*32 +: 32] = a[w*32 +: 32] + b[w*32 +: 32];
				OP_AND:  r[w*32 +: 32] = a[w*32 +: 32] & b[w*32 +: 32];
				OP_OR:   r[w*32 +: 32] = a[w*32 +: 32] | b[w*32 +: 32];
				OP_XOR:  r[w*32 +: 32] = a[w*32 +: 32] ^ b[w*32 +: 32];
				default: r[w*32 +: 32] = a[w*32 +: 32] + imm;
			endcase
		end
		return r;
	endfunction

	task automatic load_program();
		logic [31:0] nop;
		nop = 32'h0;
		// high word odd slot, low word even slot
		prog[0]  = {nop, enc_rrr(OP_XOR, 2, 5, 5)};
		prog[1]  = {nop, enc_rri(OP_ADDI, 3, 2, 256)};
		prog[2]  = {enc_rri(OP_LQD, 10, 3, 0), enc_rri(OP_ADDI, 4, 2, 504)};
		prog[3]  = {enc_rri(OP_LQD, 11, 3, 1), nop};
		prog[4]  = {enc_rri(OP_LQD, 12, 3, 2), nop};
		prog[5]  = {enc_rri(OP_STQD, 10, 4, 0), nop};
		prog[6]  = {enc_rri(OP_STQD, 11, 4, 1), nop};
		prog[7]  = {enc_rri(OP_STQD, 12, 4, 2), enc_rrr(OP_ADD, 20, 10, 11)};
		prog[8]  = {enc_rri(OP_STQD, 20, 4, 3), enc_rrr(OP_AND, 21, 10, 12)};
		prog[9]  = {enc_rri(OP_STQD, 21, 4, 4), enc_rrr(OP_OR, 22, 11, 12)};
		prog[10] = {enc_rri(OP_STQD, 22, 4, 5), enc_rrr(OP_XOR, 23, 10, 12)};
		prog[11] = {enc_rri(OP_STQD, 23, 4, 6), enc_rri(OP_ADDI, 24, 11, -3)};
		prog[12] = {enc_rri(OP_STQD, 24, 4, 7), enc_rri(OP_ADDI, 25, 12, 100)};
		// store reads r10 before the even add rewrites it
		prog[13] = {enc_rri(OP_STQD, 10, 4, 8), enc_rrr(OP_ADD, 10, 10, 11)};
		prog[14] = {enc_rri(OP_STQD, 25, 4, 9), enc_rri(OP_ADDI, 26, 2, 7)};
		prog[15] = {enc_rri(OP_STQD, 10, 4, 10), enc_rri(OP_ADDI, 27, 2, 9)};
		// both ops in the wrong slot
		prog[16] = {enc_rrr(OP_ADD, 27, 10, 11), enc_rri(OP_LQD, 26, 3, 0)};
		prog[17] = {enc_rri(OP_STQD, 26, 4, 11), nop};
		prog[18] = {enc_rri(OP_STQD, 27, 4, 12), nop};
		prog[19] = {enc_rri(OP_LQD, 28, 3, 3), enc_rri(OP_ADDI, 28, 2, 1)};
		prog[20] = {enc_rri(OP_STQD, 28, 4, 13), nop};
	endtask

	// sequential model of the program, giving the stores in order
	task automatic build_expected();
		quad_t mr [128];
		quad_t mm [256];
		logic [31:0] ev;
		logic [31:0] od;
		logic [31:0] addr;
		quad_t er;
		quad_t ores;
		quad_t o_ra;
		quad_t o_rt;
		logic e_wr;
		logic o_wr;
		for (int i = 0; i < 128; i++)
			mr[i] = '0;
		for (int i = 0; i < 256; i++)
			mm[i] = fill_quad(i * 16);
		for (int p = 0; p < NPAIRS; p++) begin
			ev = prog[p][31:0];
			od = prog[p][63:32];
			e_wr = ev[31:24] inside {OP_ADD, OP_AND, OP_OR, OP_XOR, OP_ADDI};
			o_wr = 1'b0;
			er = even_result(ev[31:24], mr[ev[16:10]], mr[ev[9:3]],
				{{22{ev[9]}}, ev[9:0]});
			o_ra = mr[od[16:10]];
			o_rt = mr[od[23:17]];
			ores = '0;
			if (od[31:24] == OP_LQD || od[31:24] == OP_STQD) begin
				addr = o_ra[31:0] + {{18{od[9]}}, od[9:0], 4'h0};
				addr[3:0] = 4'h0;
				if (od[31:24] == OP_LQD) begin
					ores = mm[addr[11:4]];
					o_wr = 1'b1;
				end else begin
					exp_addr[exp_count] = addr;
					exp_data[exp_count] = o_rt;
					mm[addr[11:4]] = o_rt;
					exp_count++;
				end
			end
			if (e_wr)
				mr[ev[23:17]] = er;
			if (o_wr)
				mr[od[23:17]] = ores;
		end
	endtask

	initial begin
		int cycles;
		rst_n_i = 1'b0;
		stallreq_fr_cache_i = 1'b0;
		load_program();
		for (int i = 0; i < ROM_PAIRS; i++)
			rom[i] = (i < NPAIRS) ? prog[i] : '0;
		for (int i = 0; i < 256; i++)
			mem[i] <= fill_quad(i * 16);
		build_expected();

		repeat (10) @(posedge clk);
		#2 rst_n_i = 1'b1;

		// cache stall in the middle of the program
		repeat (15) @(posedge clk);
		#2 stallreq_fr_cache_i = 1'b1;
		repeat (12) @(posedge clk);
		#2 stallreq_fr_cache_i = 1'b0;

		cycles = 0;
		while (store_count < exp_count && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (store_count < exp_count) begin
			$display("timeout: only %0d of %0d stores arrived", store_count, exp_count);
			timeout_count++;
		end
		// drain window to catch extra stores
		repeat (40) @(posedge clk);

		$display("errors: mismatch %0d, other %0d, timeout %0d", mismatch_count,
			other_count, timeout_count);
		if (mismatch_count + other_count + timeout_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- spu_top.f
rtl/spu_pkg.sv
rtl/spu_fetch.sv
rtl/spu_decode.sv
rtl/spu_regfile.sv
rtl/spu_even_pipe.sv
rtl/spu_odd_pipe.sv
rtl/spu_result_pipe.sv
rtl/spu_top.sv
test/spu_checker.sv
test/spu_asserts.sv
test/spu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f spu_top.f --top-module spu_tb -o spu_sim
out=$(./obj_dir/spu_sim)
echo "$out"

if grep -q "Regression passed" <<< "$out"; then
	exit 0
else
	exit 1
fi
